// File: Makefile
# Verilator build and run of the ao486 to L1.5 bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_ao486_l15_bridge
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= sim passed

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The exit status comes from the search for the pass line
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: source/ao486_l15_bridge.sv
`timescale 1ns/10ps
`default_nettype none

// Bridge between the ao486 instruction fetch port and the L1.5 cache port
module ao486_l15_bridge (
    input  logic                                clk,
    input  logic                                rst_n,

    // Core fetch request
    input  logic                                readcode_do,
    input  logic [l15_tri_pkg::core_addr_w-1:0] readcode_address,

    // L1.5 port
    output l15_tri_pkg::l15_req_t               l15_req,
    input  logic                                l15_header_ack,
    input  l15_tri_pkg::l15_ret_t               l15_ret,

    // Toward the core
    output l15_tri_pkg::fetch_resp_t            fetch_resp,
    output logic                                core_run
);

    // Fill return seen this cycle, used to retire the open request
    logic fill_ret;

    // Unpacked line and its one-cycle ready pulse
    l15_tri_pkg::fill_line_t fill_line;
    logic                    fill_ready;

    ifill_request_issuer u_ifill_request_issuer (
        .clk              (clk),
        .rst_n            (rst_n),
        .readcode_do      (readcode_do),
        .readcode_address (readcode_address),
        .l15_header_ack   (l15_header_ack),
        .fill_ret         (fill_ret),
        .l15_req          (l15_req)
    );

    ifill_return_unpacker u_ifill_return_unpacker (
        .clk        (clk),
        .rst_n      (rst_n),
        .l15_ret    (l15_ret),
        .fill_ret   (fill_ret),
        .fill_line  (fill_line),
        .fill_ready (fill_ready)
    );

    // Walks the line out to the core over four cycles
    fetch_partial_sequencer u_fetch_partial_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .fill_line  (fill_line),
        .fill_ready (fill_ready),
        .fetch_resp (fetch_resp)
    );

    // Interrupt returns go straight to the wakeup logic
    core_wakeup_detector u_core_wakeup_detector (
        .clk      (clk),
        .rst_n    (rst_n),
        .l15_ret  (l15_ret),
        .core_run (core_run)
    );

endmodule

`default_nettype wire

// File: source/core_wakeup_detector.sv
`timescale 1ns/10ps
`default_nettype none

// Releases the ao486 core once the interrupt controller sends the wakeup
// interrupt; the release holds until the next reset
module core_wakeup_detector (
    input  logic                  clk,
    input  logic                  rst_n,
    input  l15_tri_pkg::l15_ret_t l15_ret,
    output logic                  core_run
);

    // Position of the interrupt-type field inside return word 0
    localparam int unsigned int_field_lo = 16;

    logic [1:0] int_field;
    logic       wake;

    assign int_field = l15_ret.data_0[int_field_lo+1:int_field_lo];

    // Only an interrupt return with the wakeup code counts
    assign wake = l15_ret.val
               && (l15_ret.returntype == l15_tri_pkg::int_ret)
               && (int_field == l15_tri_pkg::int_wake_code);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            core_run <= 1'b0;
        end else if (wake) begin
            core_run <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: source/fetch_partial_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

// Hands a fill line to the ao486 one instruction word per cycle while the
// accumulated line grows from the low end
module fetch_partial_sequencer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  l15_tri_pkg::fill_line_t  fill_line,
    input  logic                     fill_ready,
    output l15_tri_pkg::fetch_resp_t fetch_resp
);

    localparam int unsigned word_w = l15_tri_pkg::insn_word_w;
    localparam int unsigned line_w = l15_tri_pkg::fill_words * word_w;

    // Index of the word that goes out on the next step
    logic [1:0] word_cnt;
    logic       running;

    logic              step;
    logic [1:0]        step_idx;
    logic              last_step;
    logic [word_w-1:0] step_word;
    logic [line_w-1:0] base_line;

    // A new fill restarts at word 0 with an empty line, even mid-sequence
    assign step     = fill_ready || running;
    assign step_idx = fill_ready ? 2'd0 : word_cnt;

    always_comb begin
        if (fill_ready) begin
            base_line = '0;
        end else begin
            base_line = fetch_resp.line;
        end
    end

    assign step_word = fill_line[step_idx];

    // Word 3 is the final one of the line
    assign last_step = (step_idx == 2'd3);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            word_cnt                <= 2'd0;
            running                 <= 1'b0;
            fetch_resp.partial      <= '0;
            fetch_resp.line         <= '0;
            fetch_resp.partial_done <= 1'b0;
            fetch_resp.done         <= 1'b0;
        end else if (step) begin
            // Earlier words move up one slot and the new one lands at the bottom
            fetch_resp.partial      <= step_word;
            fetch_resp.line         <= {base_line[line_w-word_w-1:0], step_word};
            fetch_resp.partial_done <= !last_step;
            fetch_resp.done         <= last_step;
            word_cnt                <= step_idx + 2'd1;
            running                 <= !last_step;
        end else begin
            // partial and line hold their last values between fills
            fetch_resp.partial_done <= 1'b0;
            fetch_resp.done         <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: source/ifill_request_issuer.sv
`timescale 1ns/10ps
`default_nettype none

// Issues one instruction-miss request per core fetch and keeps it alive
// until the L1.5 has taken the header and the fill has come back
module ifill_request_issuer (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    readcode_do,
    input  logic [l15_tri_pkg::core_addr_w-1:0]     readcode_address,
    input  logic                                    l15_header_ack,
    input  logic                                    fill_ret,
    output l15_tri_pkg::l15_req_t                   l15_req
);

    // Controller states
    localparam logic [1:0] st_idle       = 2'd0;
    localparam logic [1:0] st_requesting = 2'd1;
    localparam logic [1:0] st_waiting    = 2'd2;

    // Number of upper bits filled by the sign extension
    localparam int unsigned ext_bits =
        l15_tri_pkg::l15_addr_w - l15_tri_pkg::core_addr_w;

    logic [1:0] state;
    logic [l15_tri_pkg::core_addr_w-1:0] aligned_addr;
    logic [l15_tri_pkg::l15_addr_w-1:0]  req_addr;

    // Clear the offset inside the 32-byte fill block
    always_comb begin
        aligned_addr = readcode_address;
        aligned_addr[l15_tri_pkg::fill_align_bits-1:0] = '0;
    end

    // The L1.5 expects a 40-bit address, so bit 31 is copied upward
    assign req_addr = {{ext_bits{aligned_addr[l15_tri_pkg::core_addr_w-1]}}, aligned_addr};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state           <= st_idle;
            l15_req.val     <= 1'b0;
            l15_req.rqtype  <= '0;
            l15_req.address <= '0;
        end else begin
            case (state)
                st_idle: begin
                    // A fetch is only accepted when nothing is outstanding
                    if (readcode_do) begin
                        state           <= st_requesting;
                        l15_req.val     <= 1'b1;
                        l15_req.rqtype  <= l15_tri_pkg::imiss_rq;
                        l15_req.address <= req_addr;
                    end
                end
                st_requesting: begin
                    // A fill can in principle race the header ack, so it wins
                    if (fill_ret) begin
                        state           <= st_idle;
                        l15_req.val     <= 1'b0;
                        l15_req.rqtype  <= '0;
                        l15_req.address <= '0;
                    end else if (l15_header_ack) begin
                        // Header taken, type and address stay until the fill
                        state       <= st_waiting;
                        l15_req.val <= 1'b0;
                    end
                end
                st_waiting: begin
                    // The fill return closes the transaction
                    if (fill_ret) begin
                        state           <= st_idle;
                        l15_req.rqtype  <= '0;
                        l15_req.address <= '0;
                    end
                end
                default: begin
                    state           <= st_idle;
                    l15_req.val     <= 1'b0;
                    l15_req.rqtype  <= '0;
                    l15_req.address <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/ifill_return_unpacker.sv
`timescale 1ns/10ps
`default_nettype none

// Picks instruction-fill returns off the L1.5 return bus and turns the two
// big-endian data words into four little-endian instruction words
module ifill_return_unpacker (
    input  logic                    clk,
    input  logic                    rst_n,
    input  l15_tri_pkg::l15_ret_t   l15_ret,
    output logic                    fill_ret,
    output l15_tri_pkg::fill_line_t fill_line,
    output logic                    fill_ready
);

    localparam int unsigned word_w = l15_tri_pkg::insn_word_w;
    localparam int unsigned data_w = l15_tri_pkg::l15_data_w;

    // Reverses the byte order of one 32-bit instruction word
    function automatic logic [word_w-1:0] swap_bytes(input logic [word_w-1:0] w);
        logic [word_w-1:0] r;
        r = {w[7:0], w[15:8], w[23:16], w[31:24]};
        return r;
    endfunction

    l15_tri_pkg::fill_line_t swapped;

    // Level seen by the issuer in the same cycle as the return strobe
    assign fill_ret = l15_ret.val && (l15_ret.returntype == l15_tri_pkg::ifill_ret);

    // The upper half of each data word holds the earlier instruction word
    always_comb begin
        swapped[0] = swap_bytes(l15_ret.data_2[data_w-1:word_w]);
        swapped[1] = swap_bytes(l15_ret.data_2[word_w-1:0]);
        swapped[2] = swap_bytes(l15_ret.data_3[data_w-1:word_w]);
        swapped[3] = swap_bytes(l15_ret.data_3[word_w-1:0]);
    end

    // The line is kept between fills so the sequencer can walk through it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fill_line  <= '0;
            fill_ready <= 1'b0;
        end else begin
            fill_ready <= fill_ret;
            if (fill_ret) begin
                fill_line <= swapped;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/l15_tri_pkg.sv
`default_nettype none

// Shared codes, widths and bus layouts for the ao486 to L1.5 fetch bridge
package l15_tri_pkg;

    // Widths fixed by the ao486 fetch port and the L1.5 port
    localparam int unsigned core_addr_w = 32;
    localparam int unsigned l15_addr_w  = 40;
    localparam int unsigned l15_data_w  = 64;
    localparam int unsigned insn_word_w = 32;
    localparam int unsigned fill_words  = 4;

    // Request type for an instruction miss on the L1.5 request side
    localparam logic [4:0] imiss_rq = 5'b10000;

    // Return types seen on the L1.5 return side
    localparam logic [3:0] ifill_ret = 4'b0001;
    localparam logic [3:0] int_ret   = 4'b0111;

    // Interrupt-type field value that lets the core start running
    localparam logic [1:0] int_wake_code = 2'b01;

    // An instruction fill always covers one 32-byte block
    localparam int unsigned fill_align_bits = 5;

    // Request toward the L1.5, held stable while val waits for the header ack
    typedef struct packed {
        logic                  val;
        logic [4:0]            rqtype;
        logic [l15_addr_w-1:0] address;
    } l15_req_t;

    // Return from the L1.5; data word 1 carries nothing the bridge needs
    typedef struct packed {
        logic                  val;
        logic [3:0]            returntype;
        logic [l15_data_w-1:0] data_0;
        logic [l15_data_w-1:0] data_2;
        logic [l15_data_w-1:0] data_3;
    } l15_ret_t;

    // Four little-endian instruction words, index 0 goes to the core first
    typedef logic [fill_words-1:0][insn_word_w-1:0] fill_line_t;

    // Fetch response toward the ao486 core
    typedef struct packed {
        logic [insn_word_w-1:0]            partial;
        logic [fill_words*insn_word_w-1:0] line;
        logic                              partial_done;
        logic                              done;
    } fetch_resp_t;

endpackage

`default_nettype wire

// File: sources.f
source/l15_tri_pkg.sv
source/ifill_request_issuer.sv
source/ifill_return_unpacker.sv
source/fetch_partial_sequencer.sv
source/core_wakeup_detector.sv
source/ao486_l15_bridge.sv
test/tb_ao486_l15_bridge.sv

// File: test/tb_ao486_l15_bridge.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ao486_l15_bridge;

    localparam logic [31:0] seed = 32'hb8c9505a;

    // Twenty fill tests of at most about 60 cycles each plus a wide margin
    localparam int fill_tests      = 20;
    localparam int max_test_cycles = 60;
    localparam int timeout_cycles  = fill_tests * max_test_cycles * 3 + 400;

    logic                                clk;
    logic                                rst_n;
    logic                                readcode_do;
    logic [l15_tri_pkg::core_addr_w-1:0] readcode_address;
    logic                                l15_header_ack;
    l15_tri_pkg::l15_ret_t               l15_ret;
    l15_tri_pkg::l15_req_t               l15_req;
    l15_tri_pkg::fetch_resp_t            fetch_resp;
    logic                                core_run;

    // Free-running edge count that also drives the timeout
    int cyc = 0;

    // Expected state that the stimulus writes on rising edges only
    l15_tri_pkg::l15_req_t   exp_req;
    logic                    exp_run;
    logic                    req_busy;
    l15_tri_pkg::fill_line_t prev_words;
    l15_tri_pkg::fill_line_t cur_words;
    logic                    prev_any;
    logic                    cur_any;
    int                      fill_start;
    logic                    compare_on;

    int errors       = 0;
    int checks       = 0;
    int stall_errors = 0;
    int tests_run    = 0;

    ao486_l15_bridge u_ao486_l15_bridge (
        .clk              (clk),
        .rst_n            (rst_n),
        .readcode_do      (readcode_do),
        .readcode_address (readcode_address),
        .l15_req          (l15_req),
        .l15_header_ack   (l15_header_ack),
        .l15_ret          (l15_ret),
        .fetch_resp       (fetch_resp),
        .core_run         (core_run)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Fetch address cleared to the 32-byte block and sign-extended from bit 31
    function automatic logic [l15_tri_pkg::l15_addr_w-1:0] expected_address(
        input logic [31:0] addr);
        logic [31:0]                               aligned;
        logic signed [l15_tri_pkg::l15_addr_w-1:0] ext;
        aligned = addr & ~((32'd1 << l15_tri_pkg::fill_align_bits) - 32'd1);
        ext = $signed(aligned);
        return ext;
    endfunction

    // Big-endian fill halves become little-endian words with the upper half first
    function automatic l15_tri_pkg::fill_line_t swap_fill(input logic [63:0] d2,
                                                          input logic [63:0] d3);
        l15_tri_pkg::fill_line_t w;
        w[0] = {<<8{d2[63:32]}};
        w[1] = {<<8{d2[31:0]}};
        w[2] = {<<8{d3[63:32]}};
        w[3] = {<<8{d3[31:0]}};
        return w;
    endfunction

    // After step s the line holds words 0..s with word s at the bottom
    function automatic logic [127:0] line_after_step(input l15_tri_pkg::fill_line_t w,
                                                     input int s);
        logic [127:0] full;
        full = {w[0], w[1], w[2], w[3]};
        return full >> (32 * (3 - s));
    endfunction

    // Response k cycles after the first step where k of 4 or more is the idle hold
    function automatic l15_tri_pkg::fetch_resp_t response_at_step(
        input l15_tri_pkg::fill_line_t w, input logic any, input int k);
        l15_tri_pkg::fetch_resp_t r;
        int s;
        r = '0;
        if (any) begin
            s = (k > 3) ? 3 : k;
            r.line = line_after_step(w, s);
            // The word handed out on step s is word s of the fill
            r.partial      = w[s];
            r.partial_done = (k < 3);
            r.done         = (k == 3);
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic compare_outputs();
        l15_tri_pkg::fetch_resp_t exp_resp;
        int k;
        // Step 0 shows after the second edge from the one that took the fill
        k = (fill_start < 0) ? -1 : (cyc - fill_start - 2);
        if (k < 0) begin
            exp_resp = response_at_step(prev_words, prev_any, 4);
        end else begin
            exp_resp = response_at_step(cur_words, cur_any, k);
        end
        check_value("l15_req.val", 128'(l15_req.val), 128'(exp_req.val));
        check_value("l15_req.rqtype", 128'(l15_req.rqtype), 128'(exp_req.rqtype));
        check_value("l15_req.address", 128'(l15_req.address), 128'(exp_req.address));
        check_value("fetch_resp.partial", 128'(fetch_resp.partial), 128'(exp_resp.partial));
        check_value("fetch_resp.line", fetch_resp.line, exp_resp.line);
        check_value("fetch_resp.partial_done", 128'(fetch_resp.partial_done),
                    128'(exp_resp.partial_done));
        check_value("fetch_resp.done", 128'(fetch_resp.done), 128'(exp_resp.done));
        check_value("core_run", 128'(core_run), 128'(exp_run));
    endtask

    // Outputs are settled half a cycle after each rising edge
    always @(negedge clk) begin
        if (compare_on) begin
            compare_outputs();
        end
    end

    task automatic clear_models();
        exp_req    = '0;
        exp_run    = 1'b0;
        req_busy   = 1'b0;
        prev_words = '0;
        cur_words  = '0;
        prev_any   = 1'b0;
        cur_any    = 1'b0;
        fill_start = -1;
    endtask

    // Called at time zero or right after a rising edge
    task automatic apply_reset();
        compare_on = 1'b0;
        rst_n <= 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        clear_models();
        compare_on = 1'b1;
    endtask

    // The issuer only takes a fetch when nothing is outstanding
    task automatic issue_fetch(input logic [31:0] addr);
        @(posedge clk);
        readcode_do      <= 1'b1;
        readcode_address <= addr;
        @(posedge clk);
        readcode_do      <= 1'b0;
        readcode_address <= $urandom;
        if (!req_busy) begin
            req_busy        = 1'b1;
            exp_req.val     = 1'b1;
            exp_req.rqtype  = l15_tri_pkg::imiss_rq;
            exp_req.address = expected_address(addr);
        end
    endtask

    task automatic ack_header();
        @(posedge clk);
        l15_header_ack <= 1'b1;
        @(posedge clk);
        l15_header_ack <= 1'b0;
        exp_req.val = 1'b0;
    endtask

    task automatic wait_fill_done();
        int n;
        n = 0;
        while (fetch_resp.done !== 1'b1 && n < 8) begin
            @(negedge clk);
            n = n + 1;
        end
        if (fetch_resp.done !== 1'b1) begin
            stall_errors = stall_errors + 1;
            $display("Fill sequence did not raise done within 8 cycles at %0t", $time);
        end
        // One more cycle so done is seen low again
        @(negedge clk);
    endtask

    task automatic send_fill(input logic [63:0] d2, input logic [63:0] d3);
        l15_tri_pkg::l15_ret_t ret;
        ret.val        = 1'b1;
        ret.returntype = l15_tri_pkg::ifill_ret;
        ret.data_0     = {$urandom, $urandom};
        ret.data_2     = d2;
        ret.data_3     = d3;
        @(posedge clk);
        l15_ret <= ret;
        @(posedge clk);
        l15_ret <= '0;
        // This edge sampled the fill, so the open request is retired here
        prev_words = cur_words;
        prev_any   = cur_any;
        cur_words  = swap_fill(d2, d3);
        cur_any    = 1'b1;
        fill_start = cyc;
        exp_req    = '0;
        req_busy   = 1'b0;
        wait_fill_done();
    endtask

    // The caller states whether this return is the one that releases the core
    task automatic send_return(input logic [3:0] rtype, input logic [1:0] field,
                               input logic wakes);
        l15_tri_pkg::l15_ret_t ret;
        ret.val            = 1'b1;
        ret.returntype     = rtype;
        ret.data_0         = {$urandom, $urandom};
        ret.data_0[17:16]  = field;
        ret.data_2         = {$urandom, $urandom};
        ret.data_3         = {$urandom, $urandom};
        @(posedge clk);
        l15_ret <= ret;
        @(posedge clk);
        l15_ret <= '0;
        if (wakes) begin
            exp_run = 1'b1;
        end
        repeat (2) @(negedge clk);
    endtask

    // Must run on a rising edge so the last compare has finished
    task automatic finish_test(input string name, input int start_err);
        int found;
        found = errors + stall_errors - start_err;
        tests_run = tests_run + 1;
        if (found == 0) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, found);
        end
    endtask

    initial begin : stimulus
        logic [31:0] a;
        logic [31:0] b;
        int n;
        int c;
        int hold;
        int start_err;

        $timeformat(-9, 0, " ns", 0);
        void'($urandom(seed));
        rst_n            <= 1'b0;
        readcode_do      <= 1'b0;
        readcode_address <= '0;
        l15_header_ack   <= 1'b0;
        l15_ret          <= '0;
        apply_reset();

        start_err = errors + stall_errors;
        repeat (3) @(posedge clk);
        finish_test("reset_state", start_err);

        // Bit 31 alternates so both signs of the extension are covered
        start_err = errors + stall_errors;
        for (n = 0; n < 4; n++) begin
            a = $urandom;
            a[31] = n[0];
            issue_fetch(a);
            hold = $urandom_range(12, 1);
            repeat (hold) @(posedge clk);
            ack_header();
            send_fill({$urandom, $urandom}, {$urandom, $urandom});
        end
        @(posedge clk);
        finish_test("request_backpressure", start_err);

        start_err = errors + stall_errors;
        for (n = 0; n < 8; n++) begin
            send_fill({$urandom, $urandom}, {$urandom, $urandom});
        end
        @(posedge clk);
        finish_test("fill_sequencing", start_err);

        // A second fetch is ignored while requesting and while waiting
        start_err = errors + stall_errors;
        a = $urandom;
        b = a ^ 32'h8000_0020;
        issue_fetch(a);
        issue_fetch(b);
        ack_header();
        issue_fetch(b);
        send_fill({$urandom, $urandom}, {$urandom, $urandom});
        issue_fetch(b);
        repeat (3) @(posedge clk);
        ack_header();
        send_fill({$urandom, $urandom}, {$urandom, $urandom});
        @(posedge clk);
        finish_test("single_outstanding", start_err);

        start_err = errors + stall_errors;
        for (c = 0; c < 4; c++) begin
            if (2'(c) != l15_tri_pkg::int_wake_code) begin
                send_return(l15_tri_pkg::int_ret, 2'(c), 1'b0);
            end
        end
        send_return(4'h2, l15_tri_pkg::int_wake_code, 1'b0);
        send_return(l15_tri_pkg::int_ret, l15_tri_pkg::int_wake_code, 1'b1);
        send_fill({$urandom, $urandom}, {$urandom, $urandom});
        // Only a reset takes the core release away again
        @(posedge clk);
        apply_reset();
        repeat (3) @(posedge clk);
        finish_test("core_release", start_err);

        repeat (2) @(posedge clk);
        if (errors + stall_errors == 0) begin
            $display("Tests run: %0d, checks: %0d, errors: 0", tests_run, checks);
            $display("sim passed");
        end else begin
            $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks,
                     errors + stall_errors);
            $display("sim failed");
        end
        $finish;
    end

    initial begin : watchdog
        while (cyc < timeout_cycles) begin
            @(posedge clk);
        end
        $display("Run timed out after %0d cycles without finishing the tests", cyc);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire
